//--- list.f
aluPkg.sv
aluInterfaces.sv
aluDecode.sv
aluAddSub.sv
aluCompare.sv
aluResult.sv
exAlu.sv
exAluAssertions.sv
tbExAlu.sv

//--- Makefile
# Verilator flow for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tbExAlu
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SIM := $(OBJDIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- tbExAlu.sv
// directed testbench for the execute stage, compiled as top module tbExAlu from list.f
`default_nettype none
`timescale 1ns/1ps

module tbExAlu;
	import aluPkg::*;

	localparam int CLOCK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam logic [15:0] SEED = 16'd29159;
	localparam int RAND_PAIRS = 8;
	// upper bound on vectors of two cycles each
	localparam int VECTOR_COUNT = 400;
	localparam int HOLD_CYCLES = 4;
	localparam int MARGIN = 4;
	localparam int TIMEOUT_NS = (VECTOR_COUNT * 2 + RESET_CYCLES + HOLD_CYCLES) *
		CLOCK_PERIOD * MARGIN;

	logic clock = 1'b0;
	logic arstN;
	logic [DATA_W-1:0] valRs;
	logic [DATA_W-1:0] valRt;
	logic [IXT_W-1:0] opIxt;
	logic srT;
	logic hold;
	logic [DATA_W-1:0] resultVal;
	logic resultT;

	logic [15:0] lfsrState = SEED;
	int errorCount = 0;
	int vectorCount = 0;

	exAlu uut (
		.clock     (clock),
		.arstN     (arstN),
		.valRs     (valRs),
		.valRt     (valRt),
		.opIxt     (opIxt),
		.srT       (srT),
		.hold      (hold),
		.resultVal (resultVal),
		.resultT   (resultT)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [DATA_W-1:0] randWord();
		logic [DATA_W-1:0] w;
		w = '0;
		for (int i = 0; i < DATA_W; i++) begin
			w = {w[DATA_W-2:0], lfsrBit()};
		end
		return w;
	endfunction

	function automatic logic [IXT_W-1:0] makeIxt(input aluOp_e op, input logic qword,
			input logic zext);
		logic [IXT_W-1:0] ixt;
		ixt = '0;
		ixt[IXT_QWORD] = qword;
		ixt[IXT_ZEXT] = zext;
		ixt[3:0] = op;
		return ixt;
	endfunction

	// reference model giving {new T, value}
	function automatic logic [DATA_W:0] expectAlu(input aluOp_e op, input logic qword,
			input logic zext, input logic [DATA_W-1:0] rs, input logic [DATA_W-1:0] rt,
			input logic t);
		logic [DATA_W-1:0] ua;
		logic [DATA_W-1:0] ub;
		logic signed [DATA_W-1:0] sa;
		logic signed [DATA_W-1:0] sb;
		logic [DATA_W-1:0] val;
		logic [DATA_W:0] wide;
		logic newT;
		int cb;
		// operands as seen at the chosen width
		cb = qword ? DATA_W : HALF_W;
		ua = qword ? rs : {{HALF_W{1'b0}}, rs[HALF_W-1:0]};
		ub = qword ? rt : {{HALF_W{1'b0}}, rt[HALF_W-1:0]};
		sa = qword ? rs : {{HALF_W{rs[HALF_W-1]}}, rs[HALF_W-1:0]};
		sb = qword ? rt : {{HALF_W{rt[HALF_W-1]}}, rt[HALF_W-1:0]};
		val = rs - rt;
		newT = t;
		wide = '0;
		case (op)
			OP_ADD: val = rs + rt;
			OP_ADC: begin
				wide = {1'b0, ua} + {1'b0, ub} + {{DATA_W{1'b0}}, t};
				val = rs + rt + {{DATA_W-1{1'b0}}, t};
				newT = wide[cb];
			end
			OP_SBB: begin
				// borrow shows up as the bit above the width
				wide = {1'b0, ua} - {1'b0, ub} - {{DATA_W{1'b0}}, t};
				val = rs - rt - {{DATA_W-1{1'b0}}, t};
				newT = wide[cb];
			end
			OP_TST: begin
				val = rs & rt;
				newT = ((ua & ub) == '0);
			end
			OP_AND:   val = rs & rt;
			OP_OR:    val = rs | rt;
			OP_XOR:   val = rs ^ rt;
			OP_CMPNE: newT = (ua != ub);
			OP_CMPEQ: newT = (ua == ub);
			OP_CMPHS: newT = (ua >= ub);
			OP_CMPHI: newT = (ua > ub);
			OP_CMPGE: newT = (sa >= sb);
			OP_CMPGT: newT = (sa > sb);
			OP_CSELT: val = t ? rs : rt;
			OP_RSVD:  val = '0;
			default:  val = rs - rt;
		endcase
		if (!qword) begin
			val = zext ? {{HALF_W{1'b0}}, val[HALF_W-1:0]} :
				{{HALF_W{val[HALF_W-1]}}, val[HALF_W-1:0]};
		end
		return {newT, val};
	endfunction

	task automatic checkValue(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkOutputs(input logic [DATA_W:0] expected);
		checkValue("resultVal", expected[DATA_W-1:0], resultVal);
		checkValue("resultT", DATA_W'(expected[DATA_W]), DATA_W'(resultT));
	endtask

	task automatic runVector(input aluOp_e op, input logic qword, input logic zext,
			input logic [DATA_W-1:0] rs, input logic [DATA_W-1:0] rt, input logic t);
		logic [DATA_W:0] expected;
		expected = expectAlu(op, qword, zext, rs, rt, t);
		@(posedge clock);
		opIxt <= makeIxt(op, qword, zext);
		valRs <= rs;
		valRt <= rt;
		srT <= t;
		hold <= 1'b0;
		// captured one edge later and sampled mid cycle
		@(posedge clock);
		@(negedge clock);
		checkOutputs(expected);
		vectorCount++;
	endtask

	// quad word, long word signed, long word unsigned
	task automatic runModes(input aluOp_e op, input logic [DATA_W-1:0] rs,
			input logic [DATA_W-1:0] rt, input logic t);
		runVector(op, 1'b1, 1'b0, rs, rt, t);
		runVector(op, 1'b0, 1'b0, rs, rt, t);
		runVector(op, 1'b0, 1'b1, rs, rt, t);
	endtask

	task automatic opPair(input aluOp_e opA, input aluOp_e opB, input logic [DATA_W-1:0] rs,
			input logic [DATA_W-1:0] rt, input logic t);
		runModes(opA, rs, rt, t);
		runModes(opB, rs, rt, t);
	endtask

	task automatic resetValues();
		@(negedge clock);
		checkOutputs('0);
	endtask

	task automatic arithAndLogic();
		logic [DATA_W-1:0] rs;
		logic [DATA_W-1:0] rt;
		logic t;
		for (int i = 0; i < RAND_PAIRS; i++) begin
			rs = randWord();
			rt = randWord();
			t = lfsrBit();
			opPair(OP_ADD, OP_SUB, rs, rt, t);
			opPair(OP_AND, OP_OR, rs, rt, t);
			runModes(OP_XOR, rs, rt, t);
		end
	endtask

	task automatic carryChains();
		logic [DATA_W-1:0] rs;
		logic [DATA_W-1:0] rt;
		for (int t = 0; t < 2; t++) begin
			rs = randWord();
			rt = randWord();
			// ripple through every block and out of bit 31 and 63
			opPair(OP_ADC, OP_SBB, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, t[0]);
			opPair(OP_ADC, OP_SBB, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0, t[0]);
			opPair(OP_ADC, OP_SBB, 64'h0000_FFFF_0000_FFFF, 64'h0000_0001_0000_0001, t[0]);
			// carry or borrow out of bit 31 only
			opPair(OP_ADC, OP_SBB, 64'h0000_0001_FFFF_FFFF, 64'h0000_0000_FFFF_FFFF, t[0]);
			opPair(OP_ADC, OP_SBB, 64'h0, 64'h0, t[0]);
			opPair(OP_ADC, OP_SBB, rs, rt, t[0]);
		end
	endtask

	task automatic testAndSelect();
		logic [DATA_W-1:0] rs;
		logic [DATA_W-1:0] rt;
		for (int t = 0; t < 2; t++) begin
			rs = randWord();
			rt = randWord();
			// AND is zero in the low half only
			opPair(OP_TST, OP_CSELT, 64'hFF00_00FF_AAAA_0000, 64'h0F00_0000_0000_5555, t[0]);
			opPair(OP_TST, OP_CSELT, 64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, t[0]);
			opPair(OP_TST, OP_CSELT, rs, rt, t[0]);
		end
	endtask

	task automatic compareAll(input logic [DATA_W-1:0] rs, input logic [DATA_W-1:0] rt);
		logic t;
		t = lfsrBit();
		opPair(OP_CMPNE, OP_CMPEQ, rs, rt, t);
		opPair(OP_CMPHS, OP_CMPHI, rs, rt, t);
		opPair(OP_CMPGE, OP_CMPGT, rs, rt, t);
		runModes(OP_RSVD, rs, rt, t);
	endtask

	task automatic compareOps();
		logic [DATA_W-1:0] same;
		same = randWord();
		compareAll(same, same);
		compareAll(64'h1, 64'hFFFF_FFFF_FFFF_FFFF);
		compareAll(64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF);
		compareAll(64'h7FFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000);
		compareAll(64'h0000_0000_8000_0000, 64'h0000_0000_7FFF_FFFF);
		compareAll(64'h0000_0000_7FFF_FFFF, 64'h0000_0000_8000_0000);
		compareAll(64'h8000_0000_0000_0000, 64'h1);
		// equal low halves with different upper halves
		compareAll({~same[DATA_W-1:HALF_W], same[HALF_W-1:0]}, same);
	endtask

	task automatic holdBehavior();
		logic [DATA_W:0] heldExp;
		logic [DATA_W:0] nextExp;
		logic [DATA_W-1:0] rs;
		logic [DATA_W-1:0] rt;
		rs = randWord();
		rt = randWord();
		heldExp = expectAlu(OP_ADD, 1'b1, 1'b0, rs, rt, 1'b1);
		runVector(OP_ADD, 1'b1, 1'b0, rs, rt, 1'b1);
		// new inputs every cycle while frozen
		for (int i = 0; i < HOLD_CYCLES; i++) begin
			@(posedge clock);
			rs = randWord();
			hold <= 1'b1;
			opIxt <= makeIxt(OP_XOR, 1'b1, 1'b0);
			valRs <= rs;
			srT <= 1'b0;
			@(negedge clock);
			checkOutputs(heldExp);
		end
		nextExp = expectAlu(OP_XOR, 1'b1, 1'b0, rs, rt, 1'b0);
		@(posedge clock);
		hold <= 1'b0;
		@(posedge clock);
		@(negedge clock);
		checkOutputs(nextExp);
		vectorCount++;
	endtask

	initial begin
		arstN <= 1'b0;
		valRs <= '0;
		valRt <= '0;
		opIxt <= '0;
		srT <= 1'b0;
		hold <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		arstN <= 1'b1;
		resetValues();
		arithAndLogic();
		carryChains();
		testAndSelect();
		compareOps();
		holdBehavior();
		$display("finished %0d vectors with %0d errors", vectorCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d vectors with %0d errors", vectorCount, errorCount);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- exAluAssertions.sv
// concurrent checks on reset and hold of the execute stage output register, bound into exAlu
`default_nettype none
`timescale 1ns/1ps

module exAluAssertions (
	input logic                      clock,
	input logic                      arstN,
	input logic                      hold,
	input logic [aluPkg::DATA_W-1:0] resultVal,
	input logic                      resultT
);

	// two edges in reset, the register must be cleared by then
	resetClears: assert property (
		@(posedge clock) (!arstN && !$past(arstN)) |-> (resultVal == '0 && !resultT)
	) else $error("outputs are not zero while reset is asserted");

	holdKeeps: assert property (
		@(posedge clock) disable iff (!arstN)
		hold |=> ($stable(resultVal) && $stable(resultT))
	) else $error("outputs changed during a hold cycle");

	noUnknown: assert property (
		@(posedge clock) disable iff (!arstN) !$isunknown({resultVal, resultT})
	) else $error("unknown value on the outputs after reset");

endmodule

bind exAlu exAluAssertions checks (
	.clock     (clock),
	.arstN     (arstN),
	.hold      (hold),
	.resultVal (resultVal),
	.resultT   (resultT)
);

`default_nettype wire

//--- exAlu.sv
// top level of the integer execute stage, connects decode, adder, compare and result register
`default_nettype none
`timescale 1ns/1ps

module exAlu (
	input  logic                      clock,
	input  logic                      arstN,
	input  logic [aluPkg::DATA_W-1:0] valRs,
	input  logic [aluPkg::DATA_W-1:0] valRt,
	input  logic [aluPkg::IXT_W-1:0]  opIxt,
	input  logic                      srT,
	input  logic                      hold,
	output logic [aluPkg::DATA_W-1:0] resultVal,
	output logic                      resultT
);

	aluCtrlIf  ctrlBus ();
	aluFlagsIf flagsBus ();

	logic cmpT;

	aluDecode uDecode (
		.opIxt (opIxt),
		.srT   (srT),
		.ctrl  (ctrlBus.decode)
	);

	aluAddSub uAddSub (
		.valRs (valRs),
		.valRt (valRt),
		.ctrl  (ctrlBus.addSub),
		.flags (flagsBus.source)
	);

	aluCompare uCompare (
		.valRs (valRs),
		.valRt (valRt),
		.ctrl  (ctrlBus.compare),
		.flags (flagsBus.sink),
		.cmpT  (cmpT)
	);

	// the only clocked part of the stage
	aluResult uResult (
		.clock     (clock),
		.arstN     (arstN),
		.hold      (hold),
		.valRs     (valRs),
		.valRt     (valRt),
		.srT       (srT),
		.ctrl      (ctrlBus.result),
		.flags     (flagsBus.sink),
		.cmpT      (cmpT),
		.resultVal (resultVal),
		.resultT   (resultT)
	);

endmodule

`default_nettype wire

//--- aluResult.sv
// result value and T select with width extension, and the held output register of the stage
`default_nettype none
`timescale 1ns/1ps

module aluResult (
	input  logic                      clock,
	input  logic                      arstN,
	input  logic                      hold,
	input  logic [aluPkg::DATA_W-1:0] valRs,
	input  logic [aluPkg::DATA_W-1:0] valRt,
	input  logic                      srT,
	aluCtrlIf.result                  ctrl,
	aluFlagsIf.sink                   flags,
	input  logic                      cmpT,
	output logic [aluPkg::DATA_W-1:0] resultVal,
	output logic                      resultT
);
	import aluPkg::*;

	logic [DATA_W-1:0] andVal;
	logic [DATA_W-1:0] orVal;
	logic [DATA_W-1:0] xorVal;
	logic [DATA_W-1:0] cselVal;
	logic [DATA_W-1:0] rawVal;
	logic [DATA_W-1:0] nextVal;
	logic [DATA_W-DATA_W/2-1:0] upperFill;
	logic selCarry;
	logic nextT;

	assign andVal  = valRs & valRt;
	assign orVal   = valRs | valRt;
	assign xorVal  = valRs ^ valRt;
	assign cselVal = srT ? valRs : valRt;

	always_comb begin
		case (ctrl.valSel)
			VSEL_SUM:  rawVal = flags.sum;
			VSEL_AND:  rawVal = andVal;
			VSEL_OR:   rawVal = orVal;
			VSEL_XOR:  rawVal = xorVal;
			VSEL_CSEL: rawVal = cselVal;
			default:   rawVal = '0;
		endcase
	end

	// long word results fill the upper half by sign or with zeros
	assign upperFill = ctrl.zeroExt ? '0 : {(DATA_W-HALF_W){rawVal[HALF_W-1]}};

	assign nextVal = ctrl.isQword ? rawVal : {upperFill, rawVal[HALF_W-1:0]};

	assign selCarry = ctrl.isQword ? flags.carry64 : flags.carry32;

	always_comb begin
		case (ctrl.tSel)
			TSEL_CARRY:  nextT = selCarry;
			// SBB reports borrow out
			TSEL_BORROW: nextT = !selCarry;
			TSEL_CMP:    nextT = cmpT;
			default:     nextT = srT;
		endcase
	end

	// single pipeline stage, frozen while hold is high
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			resultVal <= '0;
			resultT   <= 1'b0;
		end else if (!hold) begin
			resultVal <= nextVal;
			resultT   <= nextT;
		end
	end

endmodule

`default_nettype wire

//--- aluCompare.sv
// compare and test predicates for the execute stage, gives the T value for TST and CMPxx
`default_nettype none
`timescale 1ns/1ps

module aluCompare (
	input  logic [aluPkg::DATA_W-1:0] valRs,
	input  logic [aluPkg::DATA_W-1:0] valRt,
	aluCtrlIf.compare                 ctrl,
	aluFlagsIf.sink                   flags,
	output logic                      cmpT
);
	import aluPkg::*;

	logic [DATA_W-1:0] andVal;
	logic tstZero;
	logic selZero;
	logic selCarry;
	logic selSign;
	logic selOver;
	logic signedGe;

	assign andVal = valRs & valRt;

	// flag set chosen once by operation width
	always_comb begin
		if (ctrl.isQword) begin
			tstZero  = (andVal == '0);
			selZero  = flags.zero64;
			selCarry = flags.carry64;
			selSign  = flags.sum[DATA_W-1];
			selOver  = flags.over64;
		end else begin
			tstZero  = (andVal[HALF_W-1:0] == '0);
			selZero  = flags.zero32;
			selCarry = flags.carry32;
			selSign  = flags.sum[HALF_W-1];
			selOver  = flags.over32;
		end
	end

	// difference sign corrected by overflow
	assign signedGe = (selSign == selOver);

	always_comb begin
		case (ctrl.cmpSel)
			CMP_TST: cmpT = tstZero;
			CMP_NE:  cmpT = !selZero;
			CMP_EQ:  cmpT = selZero;
			// no borrow means Rs >= Rt unsigned
			CMP_HS:  cmpT = selCarry;
			CMP_HI:  cmpT = selCarry && !selZero;
			CMP_GE:  cmpT = signedGe;
			CMP_GT:  cmpT = signedGe && !selZero;
			default: cmpT = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- aluAddSub.sv
// carry-select adder/subtractor of 16-bit blocks, drives sum and width flags
`default_nettype none
`timescale 1ns/1ps

module aluAddSub (
	input  logic [aluPkg::DATA_W-1:0] valRs,
	input  logic [aluPkg::DATA_W-1:0] valRt,
	aluCtrlIf.addSub                  ctrl,
	aluFlagsIf.source                 flags
);
	import aluPkg::*;

	logic [DATA_W-1:0] rtEff;
	logic [DATA_W-1:0] sumAll;

	// block sums for carry in 0 and 1, top bit is block carry out
	logic [BLOCK_W:0] blkSum0 [DATA_W/BLOCK_W];
	logic [BLOCK_W:0] blkSum1 [DATA_W/BLOCK_W];

	// carry into each block, last entry is carry out of bit 63
	logic [DATA_W/BLOCK_W:0] blkCarry;

	assign rtEff = ctrl.invertRt ? ~valRt : valRt;

	// both candidate sums per block, computed in parallel
	for (genvar i = 0; i < DATA_W/BLOCK_W; i++) begin : gBlock
		assign blkSum0[i] = {1'b0, valRs[i*BLOCK_W +: BLOCK_W]} +
			{1'b0, rtEff[i*BLOCK_W +: BLOCK_W]};
		assign blkSum1[i] = {1'b0, valRs[i*BLOCK_W +: BLOCK_W]} +
			{1'b0, rtEff[i*BLOCK_W +: BLOCK_W]} + 1'b1;
	end

	// carry ripples only through the block selects
	always_comb begin
		blkCarry[0] = ctrl.carryIn;
		for (int i = 0; i < DATA_W/BLOCK_W; i++) begin
			if (blkCarry[i]) begin
				sumAll[i*BLOCK_W +: BLOCK_W] = blkSum1[i][BLOCK_W-1:0];
				blkCarry[i+1] = blkSum1[i][BLOCK_W];
			end else begin
				sumAll[i*BLOCK_W +: BLOCK_W] = blkSum0[i][BLOCK_W-1:0];
				blkCarry[i+1] = blkSum0[i][BLOCK_W];
			end
		end
	end

	assign flags.sum = sumAll;

	assign flags.carry32 = blkCarry[HALF_W/BLOCK_W];
	assign flags.carry64 = blkCarry[DATA_W/BLOCK_W];

	assign flags.zero32 = (sumAll[HALF_W-1:0] == '0);
	assign flags.zero64 = (sumAll == '0);

	// operand signs agree and sum sign differs, Rt after inversion
	assign flags.over32 = (valRs[HALF_W-1] == rtEff[HALF_W-1]) &&
		(sumAll[HALF_W-1] != valRs[HALF_W-1]);
	assign flags.over64 = (valRs[DATA_W-1] == rtEff[DATA_W-1]) &&
		(sumAll[DATA_W-1] != valRs[DATA_W-1]);

endmodule

`default_nettype wire

//--- aluDecode.sv
// opcode decoder for the execute stage, turns opIxt and T into datapath controls
`default_nettype none
`timescale 1ns/1ps

module aluDecode (
	input  logic [aluPkg::IXT_W-1:0] opIxt,
	input  logic                     srT,
	aluCtrlIf.decode                 ctrl
);
	import aluPkg::*;

	aluOp_e op;

	assign op = aluOp_e'(opIxt[$bits(aluOp_e)-1:0]);

	assign ctrl.op      = op;
	assign ctrl.isQword = opIxt[IXT_QWORD];
	assign ctrl.zeroExt = opIxt[IXT_ZEXT];

	always_comb begin
		// plain add, keep T
		ctrl.invertRt = 1'b0;
		ctrl.carryIn  = 1'b0;
		ctrl.valSel   = VSEL_SUM;
		ctrl.tSel     = TSEL_KEEP;
		ctrl.cmpSel   = CMP_EQ;

		case (op)
			OP_ADD: begin
			end
			OP_SUB: begin
				ctrl.invertRt = 1'b1;
				ctrl.carryIn  = 1'b1;
			end
			OP_ADC: begin
				ctrl.carryIn = srT;
				ctrl.tSel    = TSEL_CARRY;
			end
			OP_SBB: begin
				// borrow in is T, so carry in is its inverse
				ctrl.invertRt = 1'b1;
				ctrl.carryIn  = !srT;
				ctrl.tSel     = TSEL_BORROW;
			end
			OP_TST: begin
				ctrl.valSel = VSEL_AND;
				ctrl.tSel   = TSEL_CMP;
				ctrl.cmpSel = CMP_TST;
			end
			OP_AND:   ctrl.valSel = VSEL_AND;
			OP_OR:    ctrl.valSel = VSEL_OR;
			OP_XOR:   ctrl.valSel = VSEL_XOR;
			OP_CSELT: ctrl.valSel = VSEL_CSEL;
			OP_RSVD:  ctrl.valSel = VSEL_ZERO;
			default: begin
				// compares all subtract Rs - Rt
				ctrl.invertRt = 1'b1;
				ctrl.carryIn  = 1'b1;
				ctrl.tSel     = TSEL_CMP;
				case (op)
					OP_CMPNE: ctrl.cmpSel = CMP_NE;
					OP_CMPHS: ctrl.cmpSel = CMP_HS;
					OP_CMPGE: ctrl.cmpSel = CMP_GE;
					OP_CMPHI: ctrl.cmpSel = CMP_HI;
					OP_CMPGT: ctrl.cmpSel = CMP_GT;
					default:  ctrl.cmpSel = CMP_EQ;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

//--- aluInterfaces.sv
// control and adder flag bundles passed between the execute stage submodules
`default_nettype none
`timescale 1ns/1ps

interface aluCtrlIf;
	import aluPkg::*;

	aluOp_e op;
	logic isQword;
	logic zeroExt;
	// adder setup
	logic invertRt;
	logic carryIn;
	// result and T steering
	aluValSel_e valSel;
	aluTSel_e tSel;
	aluCmp_e cmpSel;

	modport decode (
		output op, isQword, zeroExt, invertRt, carryIn, valSel, tSel, cmpSel
	);

	modport addSub (
		input invertRt, carryIn
	);

	modport compare (
		input cmpSel, isQword
	);

	modport result (
		input valSel, tSel, isQword, zeroExt
	);
endinterface

interface aluFlagsIf;
	import aluPkg::*;

	logic [DATA_W-1:0] sum;
	// flags for long word and quad word width
	logic carry32;
	logic carry64;
	logic zero32;
	logic zero64;
	logic over32;
	logic over64;

	modport source (
		output sum, carry32, carry64, zero32, zero64, over32, over64
	);

	modport sink (
		input sum, carry32, carry64, zero32, zero64, over32, over64
	);
endinterface

`default_nettype wire

//--- aluPkg.sv
// shared widths, opcode and select encodings for the integer execute stage; import where needed
`default_nettype none

package aluPkg;

	// datapath widths
	localparam int DATA_W  = 64;
	localparam int HALF_W  = 32;
	localparam int BLOCK_W = 16;

	// instruction extension field
	localparam int IXT_W     = 6;
	localparam int IXT_QWORD = 5;
	localparam int IXT_ZEXT  = 4;

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_ADC   = 4'd2,
		OP_SBB   = 4'd3,
		OP_TST   = 4'd4,
		OP_AND   = 4'd5,
		OP_OR    = 4'd6,
		OP_XOR   = 4'd7,
		OP_CMPNE = 4'd8,
		OP_CMPHS = 4'd9,
		OP_CMPGE = 4'd10,
		OP_RSVD  = 4'd11,
		OP_CMPEQ = 4'd12,
		OP_CMPHI = 4'd13,
		OP_CMPGT = 4'd14,
		OP_CSELT = 4'd15
	} aluOp_e;

	typedef enum logic [2:0] {
		VSEL_SUM  = 3'd0,
		VSEL_AND  = 3'd1,
		VSEL_OR   = 3'd2,
		VSEL_XOR  = 3'd3,
		VSEL_CSEL = 3'd4,
		VSEL_ZERO = 3'd5
	} aluValSel_e;

	typedef enum logic [1:0] {
		TSEL_KEEP   = 2'd0,
		TSEL_CARRY  = 2'd1,
		TSEL_BORROW = 2'd2,
		TSEL_CMP    = 2'd3
	} aluTSel_e;

	typedef enum logic [2:0] {
		CMP_TST = 3'd0,
		CMP_NE  = 3'd1,
		CMP_EQ  = 3'd2,
		CMP_HS  = 3'd3,
		CMP_HI  = 3'd4,
		CMP_GE  = 3'd5,
		CMP_GT  = 3'd6
	} aluCmp_e;

endpackage

`default_nettype wire
